//--- Bender.yml
package:
  name: exec_mem_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_pkg.sv
      - verilog/alu.sv
      - verilog/execute_stage.sv
      - verilog/memory_stage.sv
      - verilog/exec_mem_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_exec_mem.sv

//--- files.f
+incdir+verilog
verilog/core_pkg.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/exec_mem_core.sv
tb/tb_clock_gen.sv
tb/tb_exec_mem.sv

//--- tb/exec_mem_trace.txt
# name stall pc exe_fun op1 op2 rs2 mem_wen wb_sel wb_addr imm_b, then expected br taken target
# and wb wen addr data, all hex after the name
alu_add          0 00000100 01 7fffffff 00000001 00000000 0 1 01 00000000 0 00000100 1 01 80000000
alu_sub          0 00000104 02 00000005 00000007 00000000 0 1 02 00000000 0 00000104 1 02 fffffffe
alu_and          0 00000108 03 f0f0f0f0 ff00ff00 00000000 0 1 03 00000000 0 00000108 1 03 f000f000
alu_or           0 0000010c 04 f0f0f0f0 0f0f0000 00000000 0 1 04 00000000 0 0000010c 1 04 fffff0f0
alu_xor          0 00000110 05 aaaaaaaa ffff0000 00000000 0 1 05 00000000 0 00000110 1 05 5555aaaa
alu_sll          0 00000114 06 00000001 00000024 00000000 0 1 06 00000000 0 00000114 1 06 00000010
alu_srl          0 00000118 07 80000000 0000003f 00000000 0 1 07 00000000 0 00000118 1 07 00000001
alu_sra          0 0000011c 08 80000000 00000004 00000000 0 1 08 00000000 0 0000011c 1 08 f8000000
alu_slt          0 00000120 09 ffffffff 00000001 00000000 0 1 09 00000000 0 00000120 1 09 00000001
alu_sltu         0 00000124 0a ffffffff 00000001 00000000 0 1 0a 00000000 0 00000124 1 0a 00000000
alu_jalr         0 00000128 11 00001001 00000004 00000000 0 1 0b 00000000 0 00000128 1 0b 00001004
alu_copy1        0 0000012c 12 deadbeef 00000000 00000000 0 1 0c 00000000 0 0000012c 1 0c deadbeef
br_beq           0 00000130 0b 00000005 00000005 00000000 0 0 00 00000010 1 00000140 0 00 00000000
br_bne           0 00000134 0c 00000005 00000006 00000000 0 0 00 fffffff8 1 0000012c 0 00 00000000
br_blt           0 00000138 0d ffffffff 00000001 00000000 0 0 00 00000020 1 00000158 0 00 00000000
br_bge           0 0000013c 0e ffffffff 00000001 00000000 0 0 00 00000020 0 0000015c 0 00 00000000
br_bltu          0 00000140 0f ffffffff 00000001 00000000 0 0 00 00000008 0 00000148 0 00 00000000
br_bgeu          0 00000144 10 ffffffff 00000001 00000000 0 0 00 00000100 1 00000244 0 00 00000000
write_x0         0 00000148 01 00000001 00000002 00000000 0 1 00 00000000 0 00000148 0 00 00000000
bubble_mid       0 0000014c 00 00000000 00000000 00000000 0 0 00 00000000 0 0000014c 0 00 00000000
mem_sw           0 00000150 01 00000040 00000004 cafef00d 1 0 00 00000000 0 00000150 0 00 00000000
mem_lw           0 00000154 01 00000040 00000004 00000000 2 2 0d 00000000 0 00000154 1 0d cafef00d
link_pc4         0 00000158 01 00000158 00000010 00000000 0 3 01 00000000 0 00000158 1 01 0000015c
stall_src        0 0000015c 01 00000064 00000001 00000000 0 1 0e 00000030 0 0000018c 1 0e 00000065
stall_hold1      1 00000160 02 00000009 00000002 00000000 0 1 0f 00000000 0 0000018c 1 0e 00000065
stall_hold2      1 00000160 02 00000009 00000002 00000000 0 1 0f 00000000 0 0000018c 1 0e 00000065
stall_hold3      1 00000160 02 00000009 00000002 00000000 0 1 0f 00000000 0 0000018c 1 0e 00000065
stall_release    0 00000160 02 00000009 00000002 00000000 0 1 0f 00000000 0 00000160 1 0f 00000007
stall_br_src     0 00000164 0c 00000001 00000002 00000000 0 0 00 00000040 1 000001a4 0 00 00000000
stall_br_hold    1 00000168 01 00000003 00000004 00000000 0 1 10 00000000 1 000001a4 0 00 00000000
stall_br_release 0 00000168 01 00000003 00000004 00000000 0 1 10 00000000 0 00000168 1 10 00000007
bubble_end       0 0000016c 00 00000000 00000000 00000000 0 0 00 00000000 0 0000016c 0 00 00000000

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 10
) (
	output logic clk
);

	// free running, first rising edge at one half period
	initial begin
		clk = 1'b0;
		forever begin
			#(HALF_PERIOD_NS) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_exec_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module tb_exec_mem import core_pkg::*; ();

	typedef struct packed {
		logic                        taken;
		logic [`CORE_XLEN-1:0]       target;
		logic                        wen;
		logic [`CORE_REG_ADDR_W-1:0] addr;
		logic [`CORE_XLEN-1:0]       data;
		logic                        failed;
	} expect_t;

	localparam int RESET_CYCLES = 16;
	localparam int LINE_LIMIT   = 4096;
	localparam int DRAIN_LIMIT  = 16;

	logic   clk;
	logic   rst;
	logic   stall;
	ex_in_t ex_in;
	br_t    br;
	wb_t    wb;

	// br is due one falling edge after driving, wb one edge later still
	expect_t br_q[$];
	expect_t wb_q[$];
	string   br_name_q[$];
	string   wb_name_q[$];

	integer seed;
	int     pass_count;
	int     fail_count;
	bit     aborted;

	tb_clock_gen u_clock_gen (
		.clk (clk)
	);

	exec_mem_core u_dut (
		.clk   (clk),
		.rst   (rst),
		.stall (stall),
		.ex_in (ex_in),
		.br    (br),
		.wb    (wb)
	);

	task automatic check_value(input string sig, input logic [31:0] got,
			input logic [31:0] exp, inout logic failed);
		if (got !== exp) begin
			$display("mismatch at %0d ns: %s expected %h got %h", $time, sig, exp, got);
			failed = 1'b1;
		end
	endtask

	task automatic report_test(input string name, input logic failed);
		if (failed) begin
			fail_count++;
			$display("test %-18s error", name);
		end else begin
			pass_count++;
			$display("test %-18s ok", name);
		end
	endtask

	// a bubble carries junk operands, none of which may reach wb
	function automatic ex_in_t scramble_operands(input ex_in_t b);
		ex_in_t r;
		r          = b;
		r.op1_data = $random(seed);
		r.op2_data = $random(seed);
		r.rs2_data = $random(seed);
		return r;
	endfunction

	task automatic check_writeback();
		expect_t e;
		string   name;
		logic    failed;
		if (wb_q.size() > 0) begin
			e      = wb_q.pop_front();
			name   = wb_name_q.pop_front();
			failed = e.failed;
			check_value("wb.wen", {31'b0, wb.wen}, {31'b0, e.wen}, failed);
			if (e.wen) begin
				check_value("wb.addr", {27'b0, wb.addr}, {27'b0, e.addr}, failed);
				check_value("wb.data", wb.data, e.data, failed);
			end
			report_test(name, failed);
		end
	endtask

	task automatic check_branch();
		expect_t e;
		string   name;
		logic    failed;
		if (br_q.size() > 0) begin
			e      = br_q.pop_front();
			name   = br_name_q.pop_front();
			failed = e.failed;
			check_value("br.taken", {31'b0, br.taken}, {31'b0, e.taken}, failed);
			check_value("br.target", br.target, e.target, failed);
			e.failed = failed;
			wb_q.push_back(e);
			wb_name_q.push_back(name);
		end
	endtask

	initial begin
		int          fd;
		int          code;
		int          lines;
		int          drain;
		string       line;
		string       name;
		logic [31:0] f_stall;
		logic [31:0] f_pc;
		logic [31:0] f_fun;
		logic [31:0] f_op1;
		logic [31:0] f_op2;
		logic [31:0] f_rs2;
		logic [31:0] f_mwen;
		logic [31:0] f_wsel;
		logic [31:0] f_waddr;
		logic [31:0] f_imm;
		logic [31:0] f_taken;
		logic [31:0] f_target;
		logic [31:0] f_wen;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		ex_in_t      b;
		expect_t     e;
		logic        failed;

		seed       = 32'haf0a30cc;
		pass_count = 0;
		fail_count = 0;
		aborted    = 1'b0;
		rst        = 1'b1;
		stall      = 1'b0;
		// a taken branch that also writes x1, so only the reset keeps both flags low
		ex_in         = '0;
		ex_in.exe_fun = BR_BEQ;
		ex_in.wb_sel  = WB_ALU;
		ex_in.wb_addr = 5'd1;

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
		end
		@(negedge clk);
		rst   = 1'b0;
		ex_in = '0;

		failed = 1'b0;
		check_value("br.taken", {31'b0, br.taken}, 32'd0, failed);
		check_value("wb.wen", {31'b0, wb.wen}, 32'd0, failed);
		report_test("reset_state", failed);

		fd = $fopen("tb/exec_mem_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file tb/exec_mem_trace.txt");
			aborted = 1'b1;
		end

		lines = 0;
		while (!aborted && !$feof(fd)) begin
			lines++;
			if (lines > LINE_LIMIT) begin
				$display("timed out reading the trace, no end of file after %0d lines",
					LINE_LIMIT);
				aborted = 1'b1;
			end else begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 0 && line[0] != "#") begin
					code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						name, f_stall, f_pc, f_fun, f_op1, f_op2, f_rs2, f_mwen, f_wsel,
						f_waddr, f_imm, f_taken, f_target, f_wen, f_addr, f_data);
					if (code == 16) begin
						b            = '0;
						b.pc         = f_pc;
						b.exe_fun    = exe_fun_e'(f_fun[4:0]);
						b.op1_data   = f_op1;
						b.op2_data   = f_op2;
						b.rs2_data   = f_rs2;
						b.mem_wen    = mem_wen_e'(f_mwen[1:0]);
						b.wb_sel     = wb_sel_e'(f_wsel[1:0]);
						b.wb_addr    = f_waddr[`CORE_REG_ADDR_W-1:0];
						b.imm_b_sext = f_imm;
						if (b.exe_fun == EXE_X && b.mem_wen == MEM_NONE && b.wb_sel == WB_X) begin
							b = scramble_operands(b);
						end
						e.taken  = f_taken[0];
						e.target = f_target;
						e.wen    = f_wen[0];
						e.addr   = f_addr[`CORE_REG_ADDR_W-1:0];
						e.data   = f_data;
						e.failed = 1'b0;

						@(negedge clk);
						check_writeback();
						check_branch();
						stall = f_stall[0];
						ex_in = b;
						br_q.push_back(e);
						br_name_q.push_back(name);
					end else if (code > 0) begin
						$display("trace line %0d does not hold sixteen fields", lines);
						aborted = 1'b1;
					end
				end
			end
		end

		// idle bubbles push the last instructions out of the pipeline
		drain = 0;
		while (!aborted && (br_q.size() > 0 || wb_q.size() > 0)) begin
			if (drain >= DRAIN_LIMIT) begin
				$display("timed out waiting for the pipeline to drain");
				aborted = 1'b1;
			end else begin
				drain++;
				@(negedge clk);
				check_writeback();
				check_branch();
				stall = 1'b0;
				ex_in = scramble_operands('0);
			end
		end

		if (fd != 0) begin
			$fclose(fd);
		end
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (!aborted && fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module alu import core_pkg::*; (
	input  exe_fun_e              exe_fun,
	input  logic [`CORE_XLEN-1:0] op1,
	input  logic [`CORE_XLEN-1:0] op2,
	output logic [`CORE_XLEN-1:0] result,
	output logic                  br_taken
);

	logic [`CORE_XLEN-1:0] sum;
	logic [4:0]            shamt;
	logic                  eq;
	logic                  lt_s;
	logic                  lt_u;

	// the adder and the comparators are shared by several codes
	assign sum   = op1 + op2;
	assign shamt = op2[4:0];
	assign eq    = (op1 == op2);
	assign lt_s  = ($signed(op1) < $signed(op2));
	assign lt_u  = (op1 < op2);

	always_comb begin
		case (exe_fun)
			ALU_ADD:   result = sum;
			ALU_SUB:   result = op1 - op2;
			ALU_AND:   result = op1 & op2;
			ALU_OR:    result = op1 | op2;
			ALU_XOR:   result = op1 ^ op2;
			ALU_SLL:   result = op1 << shamt;
			ALU_SRL:   result = op1 >> shamt;
			ALU_SRA:   result = $unsigned($signed(op1) >>> shamt);
			ALU_SLT:   result = {{(`CORE_XLEN-1){1'b0}}, lt_s};
			ALU_SLTU:  result = {{(`CORE_XLEN-1){1'b0}}, lt_u};
			// jalr target drops bit zero of the computed address
			ALU_JALR:  result = {sum[`CORE_XLEN-1:1], 1'b0};
			ALU_COPY1: result = op1;
			default:   result = '0;
		endcase
	end

	always_comb begin
		case (exe_fun)
			BR_BEQ:  br_taken = eq;
			BR_BNE:  br_taken = !eq;
			BR_BLT:  br_taken = lt_s;
			BR_BGE:  br_taken = !lt_s;
			BR_BLTU: br_taken = lt_u;
			BR_BGEU: br_taken = !lt_u;
			default: br_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path width, also the width of every address on the core
`define CORE_XLEN 32

// five bits select one of the 32 integer registers
`define CORE_REG_ADDR_W 5

// depth of the data memory in 32 bit words
// keep this a power of two, the memory stage slices the address with $clog2
`define CORE_DMEM_WORDS 256

`endif

//--- verilog/core_pkg.sv
`default_nettype none

`include "core_params.svh"

package core_pkg;

	// encodings follow the decoder, so the numbers are fixed on purpose
	typedef enum logic [4:0] {
		EXE_X     = 5'd0,
		ALU_ADD   = 5'd1,
		ALU_SUB   = 5'd2,
		ALU_AND   = 5'd3,
		ALU_OR    = 5'd4,
		ALU_XOR   = 5'd5,
		ALU_SLL   = 5'd6,
		ALU_SRL   = 5'd7,
		ALU_SRA   = 5'd8,
		ALU_SLT   = 5'd9,
		ALU_SLTU  = 5'd10,
		BR_BEQ    = 5'd11,
		BR_BNE    = 5'd12,
		BR_BLT    = 5'd13,
		BR_BGE    = 5'd14,
		BR_BLTU   = 5'd15,
		BR_BGEU   = 5'd16,
		ALU_JALR  = 5'd17,
		ALU_COPY1 = 5'd18
	} exe_fun_e;

	typedef enum logic [1:0] {
		MEM_NONE = 2'd0,
		MEM_SW   = 2'd1,
		MEM_LW   = 2'd2
	} mem_wen_e;

	typedef enum logic [1:0] {
		WB_X   = 2'd0,
		WB_ALU = 2'd1,
		WB_MEM = 2'd2,
		WB_PC  = 2'd3
	} wb_sel_e;

	// one decoded instruction as it enters execute
	typedef struct packed {
		logic [`CORE_XLEN-1:0]       pc;
		exe_fun_e                    exe_fun;
		logic [`CORE_XLEN-1:0]       op1_data;
		logic [`CORE_XLEN-1:0]       op2_data;
		logic [`CORE_XLEN-1:0]       rs2_data;
		mem_wen_e                    mem_wen;
		wb_sel_e                     wb_sel;
		logic [`CORE_REG_ADDR_W-1:0] wb_addr;
		logic [`CORE_XLEN-1:0]       imm_b_sext;
	} ex_in_t;

	typedef struct packed {
		logic [`CORE_XLEN-1:0]       pc;
		logic [`CORE_XLEN-1:0]       alu_out;
		logic [`CORE_XLEN-1:0]       rs2_data;
		mem_wen_e                    mem_wen;
		wb_sel_e                     wb_sel;
		logic [`CORE_REG_ADDR_W-1:0] wb_addr;
	} ex_out_t;

	typedef struct packed {
		logic                  taken;
		logic [`CORE_XLEN-1:0] target;
	} br_t;

	typedef struct packed {
		logic                        wen;
		logic [`CORE_REG_ADDR_W-1:0] addr;
		logic [`CORE_XLEN-1:0]       data;
	} wb_t;

endpackage

`default_nettype wire

//--- verilog/exec_mem_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_mem_core import core_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   stall,
	input  ex_in_t ex_in,
	output br_t    br,
	output wb_t    wb
);

	ex_out_t ex_out;

	execute_stage u_execute_stage (
		.clk    (clk),
		.rst    (rst),
		.stall  (stall),
		.ex_in  (ex_in),
		.ex_out (ex_out),
		.br     (br)
	);

	// memory stage sees every execute result, stalled or not
	memory_stage u_memory_stage (
		.clk    (clk),
		.rst    (rst),
		.ex_out (ex_out),
		.wb     (wb)
	);

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module execute_stage import core_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    stall,
	input  ex_in_t  ex_in,
	output ex_out_t ex_out,
	output br_t     br
);

	ex_in_t                ex_save;
	ex_in_t                ex_cur;
	logic [`CORE_XLEN-1:0] alu_result;
	logic                  alu_br_taken;
	logic [`CORE_XLEN-1:0] br_target;

	// under stall the live inputs are ignored and the previous bundle is
	// evaluated again, so every output repeats its last value
	assign ex_cur = stall ? ex_save : ex_in;

	alu u_alu (
		.exe_fun  (ex_cur.exe_fun),
		.op1      (ex_cur.op1_data),
		.op2      (ex_cur.op2_data),
		.result   (alu_result),
		.br_taken (alu_br_taken)
	);

	assign br_target = ex_cur.pc + ex_cur.imm_b_sext;

	// the selected bundle is saved every cycle, a long stall just keeps
	// writing back the same value
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_save <= '0;
		end else begin
			ex_save <= ex_cur;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_out <= '0;
		end else begin
			ex_out.pc       <= ex_cur.pc;
			ex_out.alu_out  <= alu_result;
			ex_out.rs2_data <= ex_cur.rs2_data;
			ex_out.mem_wen  <= ex_cur.mem_wen;
			ex_out.wb_sel   <= ex_cur.wb_sel;
			ex_out.wb_addr  <= ex_cur.wb_addr;
		end
	end

	// branch outcome goes straight to the fetch side, one cycle after sampling
	always_ff @(posedge clk) begin
		if (rst) begin
			br <= '0;
		end else begin
			br.taken  <= alu_br_taken;
			br.target <= br_target;
		end
	end

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module memory_stage import core_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  ex_out_t ex_out,
	output wb_t     wb
);

	localparam int DMEM_AW = $clog2(`CORE_DMEM_WORDS);

	logic [`CORE_XLEN-1:0] dmem [0:`CORE_DMEM_WORDS-1];

	logic [DMEM_AW-1:0]    dmem_addr;
	logic [`CORE_XLEN-1:0] load_data;
	logic [`CORE_XLEN-1:0] pc_plus4;
	logic [`CORE_XLEN-1:0] wb_data;
	logic                  wb_wen;

	// word accesses only, the two low address bits are ignored
	assign dmem_addr = ex_out.alu_out[DMEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (ex_out.mem_wen == MEM_SW) begin
			dmem[dmem_addr] <= ex_out.rs2_data;
		end
	end

	// asynchronous read, the result is captured into wb on the next edge
	assign load_data = (ex_out.mem_wen == MEM_LW) ? dmem[dmem_addr] : '0;

	assign pc_plus4 = ex_out.pc + `CORE_XLEN'd4;

	always_comb begin
		case (ex_out.wb_sel)
			WB_ALU:  wb_data = ex_out.alu_out;
			WB_MEM:  wb_data = load_data;
			WB_PC:   wb_data = pc_plus4;
			default: wb_data = '0;
		endcase
	end

	// x0 is hardwired, a write to it is dropped here
	assign wb_wen = (ex_out.wb_sel != WB_X) && (ex_out.wb_addr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb <= '0;
		end else begin
			wb.wen  <= wb_wen;
			wb.addr <= ex_out.wb_addr;
			wb.data <= wb_data;
		end
	end

endmodule

`default_nettype wire
